// File: Makefile
TOP = dtwBacktraceTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f verilog.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -o simv
	./obj_dir/simv | tee sim.log
	@if grep -q "Some tests failed" sim.log; then \
		echo "simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "All tests passed" sim.log; then \
		echo "simulation did not complete"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: backtrace/btControl.sv
`timescale 1ns/1ps

module btControl (
    input  logic clk,
    input  logic nrst,
    input  logic i_btEna,
    input  logic i_atOrigin,
    output logic o_load,
    output logic o_step,
    output logic o_restart
);
    import dtwPkg::*;

    btState_e state;
    btState_e stateNext;

    always_comb begin
        stateNext = state;
        if (!i_btEna) begin
            stateNext = ST_LOAD;                  // enable low always re-arms.
        end else begin
            case (state)
                ST_LOAD: begin
                    stateNext = ST_TRACE;
                end
                ST_TRACE: begin
                    if (i_atOrigin) begin
                        stateNext = ST_DONE;      // freeze at (0,0).
                    end
                end
                ST_DONE: begin
                    stateNext = ST_DONE;
                end
                default: begin
                    stateNext = ST_LOAD;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= ST_LOAD;
        end else begin
            state <= stateNext;
        end
    end

    // every edge that lands in load shifts a row and re-arms the cursor
    assign o_load    = (stateNext == ST_LOAD);
    assign o_restart = (stateNext == ST_LOAD);

    // step only while the walk stays in trace.
    assign o_step = (state == ST_TRACE) && (stateNext == ST_TRACE);

endmodule

// File: backtrace/btCursor.sv
`timescale 1ns/1ps

module btCursor (
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     i_step,
    input  logic                     i_restart,
    input  dtwPkg::pathDir_e         i_dir,
    output logic [dtwPkg::DIAG_W-1:0] o_nit,
    output logic [dtwPkg::PE_W-1:0]   o_npe,
    output logic [dtwPkg::IDX_W-1:0]  o_tIndex,
    output logic [dtwPkg::IDX_W-1:0]  o_rIndex,
    output logic                     o_atOrigin
);
    import dtwPkg::*;

    logic [DIAG_W-1:0] nit;                       // row in the path store.
    logic [PE_W-1:0]   npe;                       // PE within the row.
    logic              samePe;                    // (i-1,j) sits in the same PE.
    logic [IDX_W-1:0]  tIndex;
    logic [IDX_W-1:0]  rIndex;

    // ====================
    // cursor registers
    // ====================
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            nit    <= DIAG_W'(NUM_DIAG - 1);
            npe    <= PE_W'(START_PE);
            samePe <= 1'b1;
            tIndex <= IDX_W'(SEQ_LEN - 1);
            rIndex <= IDX_W'(SEQ_LEN - 1);
        end else if (i_restart) begin
            nit    <= DIAG_W'(NUM_DIAG - 1);
            npe    <= PE_W'(START_PE);
            samePe <= 1'b1;
            tIndex <= IDX_W'(SEQ_LEN - 1);
            rIndex <= IDX_W'(SEQ_LEN - 1);
        end else if (i_step) begin
            case (i_dir)
                PATH_DIAG: begin
                    nit    <= nit - DIAG_W'(2);   // skips one anti-diagonal.
                    tIndex <= tIndex - IDX_W'(1);
                    rIndex <= rIndex - IDX_W'(1);
                end
                PATH_UP: begin
                    nit    <= nit - DIAG_W'(1);
                    tIndex <= tIndex - IDX_W'(1);
                    if (!samePe) begin
                        npe <= npe - PE_W'(1);
                    end
                    samePe <= ~samePe;
                end
                PATH_LEFT: begin
                    nit    <= nit - DIAG_W'(1);
                    rIndex <= rIndex - IDX_W'(1);
                    if (samePe) begin
                        npe <= npe + PE_W'(1);
                    end
                    samePe <= ~samePe;
                end
                default: begin
                    nit <= nit - DIAG_W'(1);      // no move, row still advances.
                end
            endcase
        end
    end

    assign o_nit      = nit;
    assign o_npe      = npe;
    assign o_tIndex   = tIndex;
    assign o_rIndex   = rIndex;
    assign o_atOrigin = (tIndex == '0) && (rIndex == '0);

endmodule

// File: backtrace/pathStore.sv
`timescale 1ns/1ps

module pathStore (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      i_load,
    input  logic [dtwPkg::ROW_W-1:0]  i_row,
    input  logic [dtwPkg::DIAG_W-1:0] i_nit,
    input  logic [dtwPkg::PE_W-1:0]   i_npe,
    output dtwPkg::pathDir_e          o_dir
);
    import dtwPkg::*;

    logic [ROW_W-1:0]  mem [NUM_DIAG];            // row NUM_DIAG-1 is the newest.
    logic [ROW_W-1:0]  selRow;
    logic [PATH_W-1:0] selBits;

    // ====================
    // shift memory
    // ====================
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int k = 0; k < NUM_DIAG; k++) begin
                mem[k] <= '1;                     // all-diagonal image.
            end
        end else if (i_load) begin
            for (int k = 0; k < NUM_DIAG - 1; k++) begin
                mem[k] <= mem[k+1];
            end
            mem[NUM_DIAG-1] <= i_row;
        end
    end

    // ====================
    // read selector
    // ====================
    always_comb begin
        selRow  = '0;
        selBits = PATH_NONE;
        if (int'(i_nit) < NUM_DIAG) begin
            selRow = mem[i_nit];
            if (int'(i_npe) < NUM_PE) begin
                // PE 0 in the top pair.
                selBits = selRow[(NUM_PE - 1 - int'(i_npe)) * PATH_W +: PATH_W];
            end
        end
    end

    assign o_dir = pathDir_e'(selBits);

endmodule

// File: common/dtwPkg.sv
package dtwPkg;

    // ====================
    // geometry
    // ====================
    localparam int SEQ_LEN  = 20;                 // length of both sequences.
    localparam int IDX_W    = 5;                  // test/reference index width.
    localparam int NUM_PE   = 6;                  // PEs on one anti-diagonal row.
    localparam int PE_W     = 3;
    localparam int START_PE = 2;                  // PE holding cell (19,19).
    localparam int NUM_DIAG = 2 * SEQ_LEN - 1;    // rows in the path store.
    localparam int DIAG_W   = 6;

    // ====================
    // data widths
    // ====================
    localparam int PATH_W = 2;
    localparam int ROW_W  = NUM_PE * PATH_W;      // one row as loaded per clock.
    localparam int DIST_W = 16;
    localparam int DATA_W = 32;

    // direction back to the predecessor cell
    typedef enum logic [PATH_W-1:0] {
        PATH_NONE = 2'd0,
        PATH_LEFT = 2'd1,                         // (i, j-1).
        PATH_UP   = 2'd2,                         // (i-1, j).
        PATH_DIAG = 2'd3                          // (i-1, j-1).
    } pathDir_e;

    typedef enum logic [1:0] {
        ST_LOAD  = 2'd0,
        ST_TRACE = 2'd1,
        ST_DONE  = 2'd2
    } btState_e;

endpackage

// File: rtl/dtwBacktrace.sv
`timescale 1ns/1ps

module dtwBacktrace (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      i_btEna,
    input  logic [dtwPkg::ROW_W-1:0]  i_pathRow,
    input  logic [dtwPkg::DIST_W-1:0] i_finalDist,
    output logic                      o_btEnd,
    output logic [dtwPkg::DATA_W-1:0] o_data
);
    import dtwPkg::*;

    logic              ctlLoad;
    logic              ctlStep;
    logic              ctlRestart;
    logic [DIAG_W-1:0] nit;
    logic [PE_W-1:0]   npe;
    logic [IDX_W-1:0]  tIndex;
    logic [IDX_W-1:0]  rIndex;
    logic              atOrigin;
    pathDir_e          dirSel;

    // ====================
    // control and cursor
    // ====================
    btControl btControl_i (
        .clk        (clk),
        .nrst       (nrst),
        .i_btEna    (i_btEna),
        .i_atOrigin (atOrigin),
        .o_load     (ctlLoad),
        .o_step     (ctlStep),
        .o_restart  (ctlRestart)
    );

    btCursor btCursor_i (
        .clk        (clk),
        .nrst       (nrst),
        .i_step     (ctlStep),
        .i_restart  (ctlRestart),
        .i_dir      (dirSel),
        .o_nit      (nit),
        .o_npe      (npe),
        .o_tIndex   (tIndex),
        .o_rIndex   (rIndex),
        .o_atOrigin (atOrigin)
    );

    pathStore pathStore_i (
        .clk    (clk),
        .nrst   (nrst),
        .i_load (ctlLoad),
        .i_row  (i_pathRow),
        .i_nit  (nit),
        .i_npe  (npe),
        .o_dir  (dirSel)
    );

    // ====================
    // output word
    // ====================
    traceOutput traceOutput_i (
        .clk         (clk),
        .nrst        (nrst),
        .i_btEna     (i_btEna),
        .i_finalDist (i_finalDist),
        .i_tIndex    (tIndex),
        .i_rIndex    (rIndex),
        .o_data      (o_data)
    );

    assign o_btEnd = atOrigin;

endmodule

// File: rtl/traceOutput.sv
`timescale 1ns/1ps

module traceOutput (
    input  logic                      clk,
    input  logic                      nrst,
    input  logic                      i_btEna,
    input  logic [dtwPkg::DIST_W-1:0] i_finalDist,
    input  logic [dtwPkg::IDX_W-1:0]  i_tIndex,
    input  logic [dtwPkg::IDX_W-1:0]  i_rIndex,
    output logic [dtwPkg::DATA_W-1:0] o_data
);
    import dtwPkg::*;

    logic [DIST_W-1:0] distReg;
    logic              enaQ;                      // enable as seen by the FSM.
    logic              enaQQ;
    logic              startPulse;
    logic [DIST_W-1:0] distField;

    always_ff @(posedge clk) begin
        if (!i_btEna) begin
            distReg <= i_finalDist;               // last value before trace wins.
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            enaQ  <= 1'b0;
            enaQQ <= 1'b0;
        end else begin
            enaQ  <= i_btEna;
            enaQQ <= enaQ;
        end
    end

    // first trace cycle only.
    assign startPulse = enaQ & ~enaQQ;
    assign distField  = startPulse ? distReg : '0;

    assign o_data = {3'b000, i_tIndex, 3'b000, i_rIndex, distField};

endmodule

// File: verif/dtwBacktraceTb.sv
`timescale 1ns/1ps

module dtwBacktraceTb;
    import dtwPkg::*;

    localparam int NUM_RUNS   = 5;
    localparam int HOLD_CYC   = 5;                    // extra cycles checked at (0,0).
    localparam int TRACE_CYC  = 45;
    localparam int RESET_CYC  = 10;
    localparam int MAX_CYCLES = RESET_CYC + (NUM_RUNS + 1) * (NUM_DIAG + TRACE_CYC) + 100;

    logic              clk = 1'b0;
    logic              nrst;
    logic              i_btEna;
    logic [ROW_W-1:0]  i_pathRow;
    logic [DIST_W-1:0] i_finalDist;
    logic              o_btEnd;
    logic [DATA_W-1:0] o_data;

    logic [31:0]       rngState;
    int                cycleCount;
    int                errCount;
    logic [ROW_W-1:0]  rowImg [NUM_DIAG];            // row 0 is loaded first.
    int                tExp [NUM_DIAG];              // model position after k steps.
    int                rExp [NUM_DIAG];
    int                numSteps;

    dtwBacktrace dtwBacktrace_i (
        .clk         (clk),
        .nrst        (nrst),
        .i_btEna     (i_btEna),
        .i_pathRow   (i_pathRow),
        .i_finalDist (i_finalDist),
        .o_btEnd     (o_btEnd),
        .o_data      (o_data)
    );

    initial begin
        forever begin
            #4 clk = ~clk;
        end
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < MAX_CYCLES) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
        $display("Some tests failed");
        $fatal(1, "timeout");
    end

    // ====================
    // helpers
    // ====================
    function automatic logic [31:0] nextRand();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    task automatic compareValue(input string testName, input string what,
                                input int expVal, input int actVal);
        assert (expVal == actVal) else begin
            errCount++;
            $display("ERR %s %s: expected %0d, actual %0d", testName, what, expVal, actVal);
            $display("Some tests failed");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic sampleOutputs(input string testName, input int tWant, input int rWant,
                                 input int distWant, input int endWant);
        compareValue(testName, "tIndex", tWant, int'(o_data[28:24]));
        compareValue(testName, "rIndex", rWant, int'(o_data[20:16]));
        compareValue(testName, "distance", distWant, int'(o_data[15:0]));
        compareValue(testName, "btEnd", endWant, int'(o_btEnd));
        compareValue(testName, "pad bits", 0, int'({o_data[31:29], o_data[23:21]}));
    endtask

    // walk of the all-ones image.
    function automatic void diagonalWalk();
        int t;
        int r;
        t = SEQ_LEN - 1;
        r = SEQ_LEN - 1;
        numSteps = 0;
        tExp[0] = t;
        rExp[0] = r;
        while (t > 0) begin
            t--;
            r--;
            numSteps++;
            tExp[numSteps] = t;
            rExp[numSteps] = r;
        end
    endfunction

    // random legal walk; codes off the path stay random.
    function automatic void buildWalk();
        int          t;
        int          r;
        int          npe;
        int          same;
        int          nit;
        int          nCand;
        int          pick;
        logic [31:0] rnd;
        pathDir_e    cand [3];
        pathDir_e    code;
        for (int k = 0; k < NUM_DIAG; k++) begin
            rnd = nextRand();
            rowImg[k] = rnd[27:16];
        end
        t = SEQ_LEN - 1;
        r = SEQ_LEN - 1;
        npe = START_PE;
        same = 1;
        nit = NUM_DIAG - 1;
        numSteps = 0;
        tExp[0] = t;
        rExp[0] = r;
        while (t > 0 || r > 0) begin
            nCand = 0;
            if (t > 0 && r > 0) begin
                cand[nCand] = PATH_DIAG;
                nCand++;
            end
            if (t > 0 && (same == 1 || npe > 0)) begin
                cand[nCand] = PATH_UP;
                nCand++;
            end
            if (r > 0 && (same == 0 || npe < NUM_PE - 1)) begin
                cand[nCand] = PATH_LEFT;
                nCand++;
            end
            rnd = nextRand();
            pick = int'(rnd[31:16]) % nCand;
            code = cand[pick];
            rowImg[nit][(NUM_PE - 1 - npe) * PATH_W +: PATH_W] = code;  // PE 0 on top.
            case (code)
                PATH_DIAG: begin
                    nit = nit - 2;
                    t--;
                    r--;
                end
                PATH_UP: begin
                    nit--;
                    t--;
                    if (same == 0) begin
                        npe--;
                    end
                    same = 1 - same;
                end
                default: begin
                    nit--;
                    r--;
                    if (same == 1) begin
                        npe++;
                    end
                    same = 1 - same;
                end
            endcase
            numSteps++;
            tExp[numSteps] = t;
            rExp[numSteps] = r;
        end
    endfunction

    task automatic loadRows(input string testName, output int distLast);
        logic [31:0] rnd;
        distLast = 0;
        for (int k = 0; k < NUM_DIAG; k++) begin
            rnd = nextRand();
            i_btEna = 1'b0;
            i_pathRow = rowImg[k];
            i_finalDist = rnd[31:16];
            distLast = int'(rnd[31:16]);
            @(negedge clk);
            sampleOutputs(testName, SEQ_LEN - 1, SEQ_LEN - 1, 0, 0);
        end
    endtask

    task automatic runTrace(input string testName, input int distWant);
        logic [31:0] rnd;
        int          idx;
        i_btEna = 1'b1;
        for (int k = 0; k <= numSteps + HOLD_CYC; k++) begin
            rnd = nextRand();
            i_pathRow = rnd[27:16];                   // ignored while tracing.
            i_finalDist = rnd[31:16];
            @(negedge clk);
            idx = (k < numSteps) ? k : numSteps;
            sampleOutputs(testName, tExp[idx], rExp[idx], (k == 0) ? distWant : 0,
                          (k >= numSteps) ? 1 : 0);
        end
    endtask

    // ====================
    // test sequence
    // ====================
    initial begin
        int          distLast;
        string       testName;
        logic [31:0] rnd;
        errCount = 0;
        rngState = 32'hf0369f2c;
        rnd = nextRand();
        nrst = 1'b0;
        i_btEna = 1'b0;
        i_pathRow = '1;
        i_finalDist = rnd[31:16];                     // captured while enable is low.
        distLast = int'(rnd[31:16]);
        repeat (RESET_CYC) @(negedge clk);
        nrst = 1'b1;

        @(negedge clk);
        sampleOutputs("reset", SEQ_LEN - 1, SEQ_LEN - 1, 0, 0);

        diagonalWalk();
        runTrace("resetImage", distLast);

        for (int run = 1; run <= NUM_RUNS; run++) begin
            testName = $sformatf("walk%0d", run);
            buildWalk();
            loadRows(testName, distLast);
            runTrace(testName, distLast);
        end

        if (errCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: verif/dtwBacktrace_assertions.sv
`timescale 1ns/1ps

module dtwBacktrace_assertions (
    input logic                      clk,
    input logic                      nrst,
    input logic                      i_step,
    input logic                      i_restart,
    input logic [dtwPkg::DIAG_W-1:0] i_nit,
    input logic [dtwPkg::PE_W-1:0]   i_npe,
    input logic [dtwPkg::IDX_W-1:0]  i_tIndex,
    input logic [dtwPkg::IDX_W-1:0]  i_rIndex,
    input logic                      i_atOrigin
);

    // restart and load are the same FSM term.
    stepLoadExcl: assert property (@(posedge clk) disable iff (!nrst)
        !(i_step && i_restart))
        else $error("cursor step and store load active in the same cycle");

    // at the origin with enable high the FSM sits in done.
    originHold: assert property (@(posedge clk) disable iff (!nrst)
        (i_atOrigin && !i_restart) |=> ($stable(i_nit) && $stable(i_npe)
                                        && $stable(i_tIndex) && $stable(i_rIndex)))
        else $error("cursor moved after reaching the origin");

    noStepAfterReset: assert property (@(posedge clk)
        $rose(nrst) |-> !i_step)
        else $error("cursor stepped in the first cycle after reset");

endmodule

bind btCursor dtwBacktrace_assertions cursorChecks_i (
    .clk        (clk),
    .nrst       (nrst),
    .i_step     (i_step),
    .i_restart  (i_restart),
    .i_nit      (o_nit),
    .i_npe      (o_npe),
    .i_tIndex   (o_tIndex),
    .i_rIndex   (o_rIndex),
    .i_atOrigin (o_atOrigin)
);

// File: verilog.f
common/dtwPkg.sv
backtrace/btControl.sv
backtrace/btCursor.sv
backtrace/pathStore.sv
rtl/traceOutput.sv
rtl/dtwBacktrace.sv
verif/dtwBacktrace_assertions.sv
verif/dtwBacktraceTb.sv
